// File: verilog/voxel_mem_pkg.sv
// Shared widths, sizes and word types of the voxel memory shell
package voxel_mem_pkg;

    // ------------------------------------------------------------
    // Memory geometry
    // ------------------------------------------------------------
    localparam int DATA_W     = 64;
    localparam int MEM_ADDR_W = 10;
    localparam int MEM_WORDS  = 1024;

    // External word address, one bit wider than the memory address
    localparam int BUS_ADDR_W = 11;

    // Address bit that selects the voxel window
    localparam int WIN_SEL_BIT = 10;

    // Copy length in words, wide enough to hold MEM_WORDS
    localparam int LEN_W = 11;

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------
    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // Window bit on top, word offset in the low MEM_ADDR_W bits
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

    typedef logic [LEN_W-1:0]      len_t;

endpackage

// File: verilog/mem_port_if.sv
// Word request port toward the memory
// One req strobe per access, reads answer with rvalid one cycle later
interface mem_port_if
    import voxel_mem_pkg::*;
();

    // Request side
    logic      req;
    logic      we;
    mem_addr_t addr;
    word_t     wdata;

    // Read response
    word_t     rdata;
    logic      rvalid;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  rvalid
    );

    modport memory (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output rvalid
    );

endinterface

// File: verilog/word_ram.sv
// Single-port word memory standing in for SDRAM
// Writes land on the request edge, reads return one cycle later
module word_ram
    import voxel_mem_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    mem_port_if.memory mem
);

    word_t ram [MEM_WORDS];

    // ------------------------------------------------------------
    // Storage and registered read data
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (mem.req) begin
            if (mem.we) begin
                ram[mem.addr] <= mem.wdata;
            end else begin
                mem.rdata <= ram[mem.addr];
            end
        end
    end

    // Response strobe for read requests only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.rvalid <= 1'b0;
        end else begin
            mem.rvalid <= mem.req && !mem.we;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // A request from either requester must carry a resolved address
    a_addr_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        mem.req |-> !$isunknown(mem.addr)
    );

endmodule

// File: verilog/dma_word_counter.sv
// DMA copy bookkeeping
// Source and destination pointers plus the remaining word count
module dma_word_counter
    import voxel_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  logic      step,
    input  mem_addr_t src,
    input  mem_addr_t dst,
    input  len_t      len,
    output mem_addr_t src_ptr,
    output mem_addr_t dst_ptr,
    output logic      last,
    output logic      empty
);

    len_t remaining;

    // ------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------
    // A load wins over a step in the same cycle
    always_ff @(posedge clk) begin
        if (load) begin
            src_ptr <= src;
            dst_ptr <= dst;
        end else if (step) begin
            src_ptr <= src_ptr + 1'b1;
            dst_ptr <= dst_ptr + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Remaining words
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= len;
        end else if (step && !empty) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign last  = (remaining == len_t'(1));
    assign empty = (remaining == '0);

endmodule

// File: verilog/dma_copy_fsm.sv
// DMA copy engine
// Moves one word per read, wait, write step and signals done, irq and msi
module dma_copy_fsm
    import voxel_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  mem_addr_t src,
    input  mem_addr_t dst,
    input  len_t      len,
    input  logic      irq_ack,
    mem_port_if.requester mem,
    output logic      busy,
    output logic      done,
    output logic      irq,
    output logic      msi_pulse
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_WRITE,
        ST_FINISH
    } state_t;

    state_t    state;
    state_t    state_next;
    logic      load;
    logic      step;
    mem_addr_t src_ptr;
    mem_addr_t dst_ptr;
    logic      last;
    word_t     hold;
    logic      irq_d;

    dma_word_counter u_cnt (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .step    (step),
        .src     (src),
        .dst     (dst),
        .len     (len),
        .src_ptr (src_ptr),
        .dst_ptr (dst_ptr),
        .last    (last),
        .empty   ()
    );

    // ------------------------------------------------------------
    // Next state and memory port
    // ------------------------------------------------------------
    always_comb begin
        state_next = state;
        load       = 1'b0;
        step       = 1'b0;
        mem.req    = 1'b0;
        mem.we     = 1'b0;
        mem.addr   = src_ptr;
        mem.wdata  = hold;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    load       = 1'b1;
                    // Zero length skips all memory traffic
                    state_next = (len == '0) ? ST_FINISH : ST_READ;
                end
            end
            ST_READ: begin
                mem.req    = 1'b1;
                state_next = ST_WAIT;
            end
            ST_WAIT: begin
                state_next = ST_WRITE;
            end
            ST_WRITE: begin
                mem.req    = 1'b1;
                mem.we     = 1'b1;
                mem.addr   = dst_ptr;
                step       = 1'b1;
                state_next = last ? ST_FINISH : ST_READ;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------
    // State, status and interrupt registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            irq       <= 1'b0;
            irq_d     <= 1'b0;
            msi_pulse <= 1'b0;
        end else begin
            state <= state_next;
            busy  <= state_next inside {ST_READ, ST_WAIT, ST_WRITE};
            done  <= (state_next == ST_FINISH);
            // Sticky until acknowledged while a new completion wins over the ack
            if (state_next == ST_FINISH) begin
                irq <= 1'b1;
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
            irq_d     <= irq;
            msi_pulse <= irq && !irq_d;
        end
    end

    // Word in flight between read and write
    always_ff @(posedge clk) begin
        if (state == ST_WAIT && mem.rvalid) begin
            hold <= mem.rdata;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // The read word is back by the wait state
    a_wait_has_data : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == ST_WAIT) |-> mem.rvalid
    );

    // No read response is pending at completion
    a_done_no_rvalid : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> !mem.rvalid
    );

endmodule

// File: verilog/mem_bus_arbiter.sv
// Memory bus arbiter between the DMA and the external word port
// Decodes the voxel window into a debug write strobe and zero reads
module mem_bus_arbiter
    import voxel_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      dma_busy,
    input  logic      ext_req,
    input  logic      ext_we,
    input  bus_addr_t ext_addr,
    input  word_t     ext_wdata,
    output logic      ext_gnt,
    output word_t     ext_rdata,
    output logic      ext_rvalid,
    output logic      dbg_we,
    output mem_addr_t dbg_addr,
    output word_t     dbg_wdata,
    mem_port_if.memory    dma,
    mem_port_if.requester ram
);

    logic win_hit;
    logic ext_fire;
    logic ext_rd_q;
    logic dma_rd_q;
    logic win_rd_q;

    // ------------------------------------------------------------
    // Grant and request routing
    // ------------------------------------------------------------
    assign win_hit  = ext_addr[WIN_SEL_BIT];
    // Window always granted and memory only while the DMA is idle
    assign ext_gnt  = win_hit || !dma_busy;
    assign ext_fire = ext_req && ext_gnt;

    always_comb begin
        if (dma_busy) begin
            ram.req   = dma.req;
            ram.we    = dma.we;
            ram.addr  = dma.addr;
            ram.wdata = dma.wdata;
        end else begin
            ram.req   = ext_fire && !win_hit;
            ram.we    = ext_we;
            ram.addr  = ext_addr[MEM_ADDR_W-1:0];
            ram.wdata = ext_wdata;
        end
    end

    // ------------------------------------------------------------
    // Read ownership and window responses
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dma_rd_q <= 1'b0;
            ext_rd_q <= 1'b0;
            win_rd_q <= 1'b0;
            dbg_we   <= 1'b0;
        end else begin
            dma_rd_q <= dma_busy && dma.req && !dma.we;
            ext_rd_q <= !dma_busy && ext_fire && !win_hit && !ext_we;
            win_rd_q <= ext_fire && win_hit && !ext_we;
            dbg_we   <= ext_fire && win_hit && ext_we;
        end
    end

    // Debug write payload toward the voxel core
    always_ff @(posedge clk) begin
        if (ext_fire && win_hit && ext_we) begin
            dbg_addr  <= ext_addr[MEM_ADDR_W-1:0];
            dbg_wdata <= ext_wdata;
        end
    end

    // Responses go back to whoever issued the read
    assign dma.rdata  = ram.rdata;
    assign dma.rvalid = ram.rvalid && dma_rd_q;

    // Window reads return zero
    assign ext_rvalid = (ram.rvalid && ext_rd_q) || win_rd_q;
    assign ext_rdata  = ext_rd_q ? ram.rdata : '0;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Every memory read response belongs to exactly one requester
    a_one_read_owner : assert property (
        @(posedge clk) disable iff (!rst_n)
        ram.rvalid |-> (dma_rd_q != ext_rd_q)
    );

endmodule

// File: verilog/voxel_mem_shell.sv
// Voxel memory shell top level
// Word memory shared by the DMA copy engine and the external port
module voxel_mem_shell
    import voxel_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // External word port
    input  logic      ext_req,
    input  logic      ext_we,
    input  bus_addr_t ext_addr,
    input  word_t     ext_wdata,
    output logic      ext_gnt,
    output word_t     ext_rdata,
    output logic      ext_rvalid,

    // DMA control and status
    input  logic      dma_start,
    input  mem_addr_t dma_src,
    input  mem_addr_t dma_dst,
    input  len_t      dma_len,
    output logic      dma_busy,
    output logic      dma_done,

    // Interrupts
    input  logic      irq_ack,
    output logic      irq,
    output logic      msi_pulse,

    // Voxel core debug writes
    output logic      dbg_we,
    output mem_addr_t dbg_addr,
    output word_t     dbg_wdata
);

    mem_port_if dma_port ();
    mem_port_if ram_port ();

    // ------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------
    dma_copy_fsm u_dma (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (dma_start),
        .src       (dma_src),
        .dst       (dma_dst),
        .len       (dma_len),
        .irq_ack   (irq_ack),
        .mem       (dma_port.requester),
        .busy      (dma_busy),
        .done      (dma_done),
        .irq       (irq),
        .msi_pulse (msi_pulse)
    );

    mem_bus_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .dma_busy   (dma_busy),
        .ext_req    (ext_req),
        .ext_we     (ext_we),
        .ext_addr   (ext_addr),
        .ext_wdata  (ext_wdata),
        .ext_gnt    (ext_gnt),
        .ext_rdata  (ext_rdata),
        .ext_rvalid (ext_rvalid),
        .dbg_we     (dbg_we),
        .dbg_addr   (dbg_addr),
        .dbg_wdata  (dbg_wdata),
        .dma        (dma_port.memory),
        .ram        (ram_port.requester)
    );

    word_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (ram_port.memory)
    );

endmodule

// File: dv/tb_voxel_mem_shell.sv
// Testbench for the voxel memory shell
// Table of external, window and DMA operations checked against a reference memory
module tb_voxel_mem_shell
    import voxel_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int        COPY_LEN = 6;
    localparam mem_addr_t SRC_A    = 10'h100;
    localparam mem_addr_t DST_A    = 10'h200;
    localparam mem_addr_t ALT_A    = 10'h300;

    typedef enum logic [2:0] {
        OP_MEM_WR, OP_MEM_RD, OP_WIN_WR, OP_WIN_RD, OP_DMA, OP_IRQ_ACK
    } op_kind_t;

    // addr is the external address, or the copy destination for OP_DMA
    // alt is the target of the ignored restart and of the dropped write
    typedef struct packed {
        op_kind_t  kind;
        bus_addr_t addr;
        mem_addr_t src;
        mem_addr_t alt;
        len_t      len;
        word_t     data;
        word_t     expected;
    } op_t;

    logic      clk, rst_n;
    logic      ext_req, ext_we, ext_gnt, ext_rvalid;
    bus_addr_t ext_addr;
    word_t     ext_wdata, ext_rdata;
    logic      dma_start, dma_busy, dma_done;
    mem_addr_t dma_src, dma_dst;
    len_t      dma_len;
    logic      irq_ack, irq, msi_pulse;
    logic      dbg_we;
    mem_addr_t dbg_addr;
    word_t     dbg_wdata;

    op_t   ops[$];
    word_t ref_mem [MEM_WORDS];
    word_t rng_state = 64'd96;
    int    cycle_count = 0;
    int    cycle_limit = 100000;

    voxel_mem_shell u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(string what, word_t exp, word_t act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", what, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %b actual %b", what, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Table construction with the reference memory
    // ------------------------------------------------------------
    task automatic add_access(op_kind_t kind, mem_addr_t offset, word_t data);
        op_t op;
        op = '0;
        op.kind = kind;
        op.addr = bus_addr_t'(offset);
        op.addr[WIN_SEL_BIT] = (kind == OP_WIN_WR || kind == OP_WIN_RD);
        op.data = data;
        // Window traffic never touches memory and window reads return zero
        if (kind == OP_MEM_WR) ref_mem[offset] = data;
        op.expected = (kind == OP_MEM_RD) ? ref_mem[offset] : '0;
        ops.push_back(op);
    endtask

    task automatic add_copy(mem_addr_t src, mem_addr_t dst, len_t len);
        op_t op;
        op = '0;
        op.kind = OP_DMA;
        op.addr = bus_addr_t'(dst);
        op.src  = src;
        op.alt  = ALT_A;
        op.len  = len;
        op.data = next_random();
        ops.push_back(op);
        // Word by word in order, so overlapping forward copies repeat data
        for (int i = 0; i < int'(len); i++) begin
            ref_mem[mem_addr_t'(int'(dst) + i)] = ref_mem[mem_addr_t'(int'(src) + i)];
        end
    endtask

    task automatic add_irq_ack();
        op_t op;
        op = '0;
        op.kind     = OP_IRQ_ACK;
        op.expected = word_t'(1);
        ops.push_back(op);
    endtask

    task automatic build_table();
        mem_addr_t rnd_addr [8];
        foreach (rnd_addr[i]) begin
            rnd_addr[i] = mem_addr_t'(next_random());
            add_access(OP_MEM_WR, rnd_addr[i], next_random());
        end
        foreach (rnd_addr[i]) add_access(OP_MEM_RD, rnd_addr[i], '0);
        // Read in the cycle right after the write
        add_access(OP_MEM_WR, 10'h3f0, next_random());
        add_access(OP_MEM_RD, 10'h3f0, '0);
        for (int i = 0; i < COPY_LEN; i++) begin
            add_access(OP_MEM_WR, mem_addr_t'(int'(SRC_A) + i), next_random());
            add_access(OP_MEM_WR, mem_addr_t'(int'(ALT_A) + i), next_random());
        end
        add_access(OP_WIN_WR, SRC_A, next_random());
        add_access(OP_MEM_RD, SRC_A, '0);
        add_access(OP_WIN_RD, SRC_A + 1'b1, '0);
        add_copy(SRC_A, DST_A, len_t'(COPY_LEN));
        for (int i = 0; i < COPY_LEN; i++) begin
            add_access(OP_MEM_RD, mem_addr_t'(int'(DST_A) + i), '0);
            add_access(OP_MEM_RD, mem_addr_t'(int'(ALT_A) + i), '0);
        end
        add_irq_ack();
        add_copy(SRC_A, 10'h3a0, '0);
        add_irq_ack();
        add_copy(DST_A, DST_A + 2'd2, len_t'(3));
        for (int i = 0; i < 5; i++) add_access(OP_MEM_RD, mem_addr_t'(int'(DST_A) + i), '0);
        add_irq_ack();
    endtask

    // ------------------------------------------------------------
    // Operation drivers
    // ------------------------------------------------------------
    task automatic run_copy(op_t op, string name);
        int busy_cycles;
        busy_cycles = 1;
        dma_src   = op.src;
        dma_dst   = op.addr[MEM_ADDR_W-1:0];
        dma_len   = op.len;
        dma_start = 1'b1;
        next_cycle();
        dma_start = 1'b0;
        if (op.len != '0) begin
            check_bit({name, " busy"}, 1'b1, dma_busy);
            // Restart and memory write while busy must both be dropped
            dma_dst   = op.alt;
            dma_start = 1'b1;
            ext_req   = 1'b1;
            ext_we    = 1'b1;
            ext_addr  = bus_addr_t'(op.alt);
            ext_wdata = op.data;
            #1;
            check_bit({name, " gnt memory"}, 1'b0, ext_gnt);
            next_cycle();
            dma_start = 1'b0;
            ext_req   = 1'b0;
            ext_addr[WIN_SEL_BIT] = 1'b1;
            #1;
            check_bit({name, " gnt window"}, 1'b1, ext_gnt);
            while (!dma_done) begin
                check_bit({name, " busy"}, 1'b1, dma_busy);
                busy_cycles++;
                next_cycle();
            end
            check_word({name, " busy cycles"}, word_t'(3 * int'(op.len)), word_t'(busy_cycles));
        end
        check_bit({name, " done"}, 1'b1, dma_done);
        check_bit({name, " busy at done"}, 1'b0, dma_busy);
        check_bit({name, " irq"}, 1'b1, irq);
        check_bit({name, " msi early"}, 1'b0, msi_pulse);
        next_cycle();
        check_bit({name, " msi"}, 1'b1, msi_pulse);
        check_bit({name, " done pulse"}, 1'b0, dma_done);
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            check_bit({name, " msi after"}, 1'b0, msi_pulse);
            check_bit({name, " no second done"}, 1'b0, dma_done);
            check_bit({name, " idle"}, 1'b0, dma_busy);
            check_bit({name, " irq held"}, 1'b1, irq);
        end
    endtask

    task automatic apply_op(op_t op, int idx);
        string name;
        name = $sformatf("%s #%0d", op.kind.name(), idx);
        case (op.kind)
            OP_MEM_WR, OP_WIN_WR: begin
                ext_req   = 1'b1;
                ext_we    = 1'b1;
                ext_addr  = op.addr;
                ext_wdata = op.data;
                next_cycle();
                ext_req = 1'b0;
                check_bit({name, " dbg_we"}, op.kind == OP_WIN_WR, dbg_we);
                if (op.kind == OP_WIN_WR) begin
                    check_word({name, " dbg_addr"}, word_t'(op.addr[MEM_ADDR_W-1:0]),
                               word_t'(dbg_addr));
                    check_word({name, " dbg_wdata"}, op.data, dbg_wdata);
                    next_cycle();
                    check_bit({name, " dbg_we low"}, 1'b0, dbg_we);
                end
            end
            OP_MEM_RD, OP_WIN_RD: begin
                ext_req  = 1'b1;
                ext_we   = 1'b0;
                ext_addr = op.addr;
                next_cycle();
                ext_req = 1'b0;
                check_bit({name, " rvalid"}, 1'b1, ext_rvalid);
                check_word({name, " rdata"}, op.expected, ext_rdata);
                next_cycle();
                check_bit({name, " rvalid low"}, 1'b0, ext_rvalid);
            end
            OP_DMA: begin
                run_copy(op, name);
            end
            default: begin
                check_bit({name, " irq before ack"}, op.expected[0], irq);
                irq_ack = 1'b1;
                next_cycle();
                irq_ack = 1'b0;
                check_bit({name, " irq cleared"}, 1'b0, irq);
            end
        endcase
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        ext_req   = 1'b0;
        ext_we    = 1'b0;
        ext_addr  = '0;
        ext_wdata = '0;
        dma_start = 1'b0;
        dma_src   = '0;
        dma_dst   = '0;
        dma_len   = '0;
        irq_ack   = 1'b0;
        build_table();
        // Every entry may take as long as the longest copy
        cycle_limit = ops.size() * (3 * COPY_LEN + 4) + 64;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_bit("reset ext_gnt", 1'b1, ext_gnt);
        check_bit("reset ext_rvalid", 1'b0, ext_rvalid);
        check_bit("reset dma_busy", 1'b0, dma_busy);
        check_bit("reset dma_done", 1'b0, dma_done);
        check_bit("reset irq", 1'b0, irq);
        check_bit("reset msi_pulse", 1'b0, msi_pulse);
        check_bit("reset dbg_we", 1'b0, dbg_we);

        foreach (ops[i]) apply_op(ops[i], i);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: voxel_mem_shell.f
verilog/voxel_mem_pkg.sv
verilog/mem_port_if.sv
verilog/word_ram.sv
verilog/dma_word_counter.sv
verilog/dma_copy_fsm.sv
verilog/mem_bus_arbiter.sv
verilog/voxel_mem_shell.sv
dv/tb_voxel_mem_shell.sv

// File: run_sim.sh
#!/bin/sh
# Builds the voxel memory shell testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_voxel_mem_shell \
    -f voxel_mem_shell.f \
    -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation passed"
